// File: common/stream_settings.svh
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

// Width of one stream word, header or data
`define WORD_BITS 32

// RAM words, also the credit upstream starts with
`define BUF_DEPTH 64

// Credits the buffer holds towards downstream after reset
`define OUT_CREDITS 4

`endif

// File: common/stream_types_pkg.sv
`include "stream_settings.svh"

package stream_types_pkg;

    // Header layout of the first word of a frame
    typedef struct packed {
        logic [7:0]  frame_id;
        logic [7:0]  word_count;   // Data words after the header
        logic [15:0] reserved;
    } header_view_t;

    // One stream word, seen as plain data or as a header
    typedef union packed {
        logic [`WORD_BITS-1:0] data;
        header_view_t          header;
    } stream_word_u;

    // Upstream beat, sent only against a credit
    typedef struct packed {
        logic         valid;
        stream_word_u word;
    } in_beat_t;

    // Downstream beat, 35 bits
    typedef struct packed {
        logic         valid;
        logic         is_header;    // First word of a frame
        logic         last;         // Final word of a frame
        stream_word_u word;
    } out_beat_t;

endpackage

// File: common/buffer_ctrl_pkg.sv
`include "stream_settings.svh"

package buffer_ctrl_pkg;

    // RAM address
    typedef logic [$clog2(`BUF_DEPTH)-1:0] buf_addr_t;

    // One extra bit so a full buffer fits
    typedef logic [$clog2(`BUF_DEPTH):0] occupancy_t;

    // Downstream credit count
    typedef logic [3:0] credit_t;

    // Read request, one word per asserted cycle
    typedef struct packed {
        logic valid;   // Advances the read address
    } read_req_t;

endpackage

// File: block_buffer/dual_port_ram.sv
module dual_port_ram #(
    parameter int RAM_WIDTH = 32,
    parameter int RAM_DEPTH = 64
) (
    input  logic                         clk_in,
    input  logic                         rst_in,

    // Port B, write side
    input  logic                         wr_en,
    input  logic [$clog2(RAM_DEPTH)-1:0] wr_addr,
    input  logic [RAM_WIDTH-1:0]         wr_data,

    // Port A, read side
    input  logic [$clog2(RAM_DEPTH)-1:0] rd_addr,
    output logic [RAM_WIDTH-1:0]         rd_data
);

    logic [RAM_WIDTH-1:0] mem [RAM_DEPTH];
    logic [RAM_WIDTH-1:0] ram_q;          // First read stage

    always_ff @(posedge clk_in) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Read-first, a same-cycle write to rd_addr is not seen here
    always_ff @(posedge clk_in) begin
        ram_q <= mem[rd_addr];
    end

    // Output register, second cycle of latency
    always_ff @(posedge clk_in) begin
        if (rst_in)
            rd_data <= '0;
        else
            rd_data <= ram_q;
    end

endmodule

// File: block_buffer/bram_blocks_rw.sv
`include "stream_settings.svh"

module bram_blocks_rw
    import stream_types_pkg::*;
    import buffer_ctrl_pkg::*;
(
    input  logic         clk_in,
    input  logic         rst_in,

    input  logic         wr_valid,
    input  stream_word_u wr_word,

    input  read_req_t    read_req,
    output stream_word_u rd_word,
    output logic         rd_valid    // Lines up with rd_word
);

    buf_addr_t wr_addr;
    buf_addr_t rd_addr;
    logic      valid_pipe1;

    // Write address, one step per accepted word
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_addr <= '0;
        end else if (wr_valid) begin
            if (wr_addr == buf_addr_t'(`BUF_DEPTH - 1))
                wr_addr <= '0;
            else
                wr_addr <= wr_addr + buf_addr_t'(1);
        end
    end

    // Read address follows the same ring
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rd_addr <= '0;
        end else if (read_req.valid) begin
            if (rd_addr == buf_addr_t'(`BUF_DEPTH - 1))
                rd_addr <= '0;
            else
                rd_addr <= rd_addr + buf_addr_t'(1);
        end
    end

    // Two stages to match the RAM read latency
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_pipe1 <= 1'b0;
            rd_valid    <= 1'b0;
        end else begin
            valid_pipe1 <= read_req.valid;
            rd_valid    <= valid_pipe1;
        end
    end

    dual_port_ram #(
        .RAM_WIDTH (`WORD_BITS),
        .RAM_DEPTH (`BUF_DEPTH)
    ) ram_i (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .wr_en   (wr_valid),       // Port B, writes only
        .wr_addr (wr_addr),
        .wr_data (wr_word.data),
        .rd_addr (rd_addr),        // Port A, reads only
        .rd_data (rd_word.data)
    );

endmodule

// File: src/stream_ctrl.sv
`include "stream_settings.svh"

module stream_ctrl
    import buffer_ctrl_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_in,

    input  logic      wr_valid,     // Word written this cycle
    input  logic      out_credit,   // Downstream consumed a word

    output read_req_t read_req,
    output logic      in_credit     // Slot freed, credit back upstream
);

    occupancy_t occupancy;      // Words held in RAM
    credit_t    credits;        // Words downstream can still take
    logic       issue;

    // Read whenever there is a word and somewhere to send it
    assign issue = (occupancy != '0) && (credits != '0);

    assign read_req.valid = issue;
    assign in_credit      = issue;  // RAM is read-first, slot reusable at once

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            occupancy <= '0;
        end else begin
            case ({wr_valid, issue})
                2'b10:   occupancy <= occupancy + occupancy_t'(1);
                2'b01:   occupancy <= occupancy - occupancy_t'(1);
                default: occupancy <= occupancy;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            credits <= credit_t'(`OUT_CREDITS);
        end else begin
            case ({out_credit, issue})
                2'b10:   credits <= credits + credit_t'(1);
                2'b01:   credits <= credits - credit_t'(1);
                default: credits <= credits;
            endcase
        end
    end

    // A full buffer only takes a word in a cycle that frees a slot
    assert property (@(posedge clk_in) disable iff (rst_in)
        wr_valid |-> (occupancy != occupancy_t'(`BUF_DEPTH)) || issue)
        else $error("stream_ctrl: write into full buffer");

    // Downstream must not return more credits than it was given
    assert property (@(posedge clk_in) disable iff (rst_in)
        credits <= credit_t'(`OUT_CREDITS))
        else $error("stream_ctrl: downstream credit overflow");

endmodule

// File: src/frame_tracker.sv
module frame_tracker
    import stream_types_pkg::*;
(
    input  logic         clk_in,
    input  logic         rst_in,

    input  stream_word_u rd_word,
    input  logic         rd_valid,

    output out_beat_t    out_beat
);

    logic         expect_header;   // Next valid word opens a frame
    logic [7:0]   remaining;       // Data words still to come
    logic         word_last;

    logic         beat_valid;
    logic         beat_header;
    logic         beat_last;
    stream_word_u beat_word;

    // Header with a zero count closes its own frame
    always_comb begin
        if (expect_header)
            word_last = (rd_word.header.word_count == 8'd0);
        else
            word_last = (remaining == 8'd1);
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            expect_header <= 1'b1;
            remaining     <= '0;
            beat_valid    <= 1'b0;
        end else begin
            beat_valid <= rd_valid;
            if (rd_valid) begin
                expect_header <= word_last;
                if (expect_header)
                    remaining <= rd_word.header.word_count;
                else
                    remaining <= remaining - 8'd1;
            end
        end
    end

    // Tags and payload, qualified by beat_valid
    always_ff @(posedge clk_in) begin
        if (rd_valid) begin
            beat_header <= expect_header;
            beat_last   <= word_last;
            beat_word   <= rd_word;
        end
    end

    assign out_beat = '{valid:     beat_valid,
                        is_header: beat_header,
                        last:      beat_last,
                        word:      beat_word};

    // Header closes the frame only when it announced no data
    assert property (@(posedge clk_in) disable iff (rst_in)
        (out_beat.valid && out_beat.is_header && out_beat.last) |-> (remaining == 8'd0))
        else $error("frame_tracker: header marked last with data pending");

endmodule

// File: src/block_stream_top.sv
module block_stream_top
    import stream_types_pkg::*;
    import buffer_ctrl_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_in,

    input  in_beat_t  in_beat,
    output logic      in_credit,

    output out_beat_t out_beat,
    input  logic      out_credit
);

    read_req_t    read_req;
    stream_word_u rd_word;
    logic         rd_valid;

    // Occupancy and credit bookkeeping
    stream_ctrl ctrl_i (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .wr_valid   (in_beat.valid),
        .out_credit (out_credit),
        .read_req   (read_req),
        .in_credit  (in_credit)
    );

    // Ring buffer in block RAM
    bram_blocks_rw buffer_i (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .wr_valid (in_beat.valid),
        .wr_word  (in_beat.word),
        .read_req (read_req),
        .rd_word  (rd_word),
        .rd_valid (rd_valid)
    );

    frame_tracker tracker_i (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .rd_word  (rd_word),
        .rd_valid (rd_valid),
        .out_beat (out_beat)      // Three cycles after read_req
    );

endmodule

// File: sim/tb_block_stream.sv
`include "stream_settings.svh"

module tb_block_stream
    import stream_types_pkg::*;
    import buffer_ctrl_pkg::*;
();

    localparam int         WAIT_LIMIT = 2000;
    localparam int         ENTRY_MAX  = 256;
    localparam logic [3:0] TAG_DATA   = 4'h0;
    localparam logic [3:0] TAG_HEADER = 4'h1;
    localparam logic [3:0] TAG_MARK   = 4'h8;
    localparam logic [3:0] TAG_END    = 4'hf;

    logic      clk_in;
    logic      rst_in;
    in_beat_t  in_beat;
    logic      in_credit;
    out_beat_t out_beat;
    logic      out_credit;

    logic [35:0]  entries [ENTRY_MAX];  // Tag nibble above one word
    stream_word_u send_q[$];            // Words still to send upstream
    out_beat_t    exp_q[$];             // Predicted output beats

    int         up_credits;
    int         owed;          // Beats consumed whose credit is not yet returned
    int         gap_left;      // Cycles until the next credit return
    bit         ds_stall;
    int         words_sent;
    int         credit_pulses;
    int         beats_seen;
    int         error_count;
    int         tests_run;
    int         tests_failed;
    logic [7:0] frame_left;    // Data words left in the predicted frame

    block_stream_top dut (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .in_beat    (in_beat),
        .in_credit  (in_credit),
        .out_beat   (out_beat),
        .out_credit (out_credit)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    task automatic check_beat(out_beat_t got, out_beat_t exp, string what);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s: hdr,last,word got %0b,%0b,%08h expected %0b,%0b,%08h",
                     $time, what, got.is_header, got.last, got.word.data,
                     exp.is_header, exp.last, exp.word.data);
        end
    endtask

    task automatic check_count(occupancy_t got, occupancy_t exp, string what);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s: got %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic abort_on_timeout(string what);
        $display("Timeout while waiting for %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    // Sample outputs at the falling edge and then drive the next inputs
    task automatic tick();
        out_beat_t exp;
        @(negedge clk_in);
        if (in_credit) begin
            up_credits++;
            credit_pulses++;
        end
        if (out_beat.valid) begin
            beats_seen++;
            owed++;
            if (exp_q.size() == 0) begin
                error_count++;
                $display("Beat with word %08h arrived when none was expected", out_beat.word.data);
            end else begin
                exp = exp_q.pop_front();
                check_beat(out_beat, exp, "output beat");
            end
        end
        in_beat.valid = 1'b0;
        if (send_q.size() > 0 && up_credits > 0) begin
            in_beat.valid = 1'b1;
            in_beat.word  = send_q.pop_front();
            up_credits--;
            words_sent++;
        end
        out_credit = 1'b0;
        if (!ds_stall && owed > 0) begin
            if (gap_left == 0) begin
                out_credit = 1'b1;
                owed--;
                gap_left = int'($urandom_range(3, 0));
            end else begin
                gap_left--;
            end
        end
    endtask

    // A header restarts the countdown and each data word takes one off
    task automatic queue_word(logic [35:0] entry);
        stream_word_u word;
        out_beat_t    beat;
        word.data      = entry[31:0];
        beat.valid     = 1'b1;
        beat.word      = word;
        beat.is_header = (entry[35:32] == TAG_HEADER);
        if (beat.is_header)
            frame_left = word.header.word_count;
        else
            frame_left = frame_left - 8'd1;
        beat.last = (frame_left == 8'd0);
        send_q.push_back(word);
        exp_q.push_back(beat);
    endtask

    task automatic wait_drain(string what);
        int t;
        t = 0;
        while ((exp_q.size() > 0 || send_q.size() > 0 || owed > 0) && t < WAIT_LIMIT) begin
            tick();
            t++;
        end
        if (exp_q.size() > 0 || send_q.size() > 0 || owed > 0)
            abort_on_timeout(what);
        repeat (2) tick();   // Last credit return reaches the DUT
        check_count(occupancy_t'(up_credits), occupancy_t'(`BUF_DEPTH), "upstream credits");
    endtask

    task automatic report_test(int id, string name, int errs_before);
        tests_run++;
        if (error_count != errs_before) begin
            tests_failed++;
            $display("Test %0d %s: FAIL, %0d errors", id, name, error_count - errs_before);
        end else begin
            $display("Test %0d %s: PASS", id, name);
        end
    endtask

    task automatic run_flow();
        int errs;
        int sent0;
        int pulses0;
        errs    = error_count;
        sent0   = words_sent;
        pulses0 = credit_pulses;
        ds_stall = 1'b0;
        wait_drain("frames to drain");
        check_count(occupancy_t'(credit_pulses - pulses0), occupancy_t'(words_sent - sent0),
                    "in_credit pulses of this test");
        report_test(2, "frames in order", errs);
    endtask

    task automatic run_totals();
        int errs;
        errs = error_count;
        repeat (8) begin   // A drained buffer frees no further slots
            tick();
            check_bit(in_credit, 1'b0, "in_credit when empty");
        end
        check_count(occupancy_t'(credit_pulses), occupancy_t'(words_sent), "in_credit total");
        report_test(3, "credit totals", errs);
    endtask

    task automatic run_stall();
        int errs;
        int beats0;
        int t;
        errs   = error_count;
        beats0 = beats_seen;
        t      = 0;
        ds_stall = 1'b1;
        while (beats_seen - beats0 < `OUT_CREDITS && t < WAIT_LIMIT) begin
            tick();
            t++;
        end
        if (beats_seen - beats0 < `OUT_CREDITS)
            abort_on_timeout("beats before the stall");
        repeat (24) tick();   // Window where no further beat may appear
        check_count(occupancy_t'(beats_seen - beats0), occupancy_t'(`OUT_CREDITS),
                    "beats while stalled");
        ds_stall = 1'b0;
        wait_drain("stalled words to drain");
        report_test(4, "downstream stall", errs);
    endtask

    task automatic run_fill();
        int errs;
        int beats0;
        int t;
        errs   = error_count;
        beats0 = beats_seen;
        t      = 0;
        ds_stall = 1'b1;
        while (send_q.size() > 0 && t < WAIT_LIMIT) begin
            tick();
            t++;
        end
        if (send_q.size() > 0)
            abort_on_timeout("upstream to fill the buffer");
        repeat (2) tick();
        check_count(dut.ctrl_i.occupancy, occupancy_t'(`BUF_DEPTH), "occupancy when full");
        check_count(occupancy_t'(up_credits), '0, "upstream credits when full");
        check_count(occupancy_t'(beats_seen - beats0), occupancy_t'(`OUT_CREDITS),
                    "beats while filling");
        ds_stall = 1'b0;
        wait_drain("full buffer to drain");
        report_test(5, "buffer fill", errs);
    endtask

    task automatic run_marked_test(logic [7:0] id);
        case (id)
            8'd2:    run_flow();
            8'd3:    run_totals();
            8'd4:    run_stall();
            8'd5:    run_fill();
            default: begin
                error_count++;
                $display("Input file names test %0d, which does not exist", id);
            end
        endcase
    endtask

    initial begin
        int         idx;
        int         errs;
        logic [7:0] test_id;
        void'($urandom(99041));
        rst_in        = 1'b1;
        in_beat       = '0;
        out_credit    = 1'b0;
        ds_stall      = 1'b0;
        up_credits    = `BUF_DEPTH;
        owed          = 0;
        gap_left      = 0;
        words_sent    = 0;
        credit_pulses = 0;
        beats_seen    = 0;
        error_count   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        frame_left    = '0;
        for (int i = 0; i < ENTRY_MAX; i++)
            entries[i] = {TAG_END, 32'(i)};
        $readmemh("sim/stream_input.txt", entries);

        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        errs = error_count;
        repeat (8) begin
            tick();
            check_bit(out_beat.valid, 1'b0, "out_beat.valid after reset");
            check_bit(in_credit, 1'b0, "in_credit after reset");
        end
        report_test(1, "idle after reset", errs);

        // Each marker opens a test whose words follow up to the next marker
        idx = 0;
        while (idx < ENTRY_MAX && entries[idx][35:32] != TAG_END) begin
            if (entries[idx][35:32] == TAG_MARK) begin
                test_id = entries[idx][7:0];
                idx++;
                while (idx < ENTRY_MAX && (entries[idx][35:32] == TAG_DATA ||
                                           entries[idx][35:32] == TAG_HEADER)) begin
                    queue_word(entries[idx]);
                    idx++;
                end
                run_marked_test(test_id);
            end else begin
                error_count++;
                $display("Input file entry %0d is not a word of any test", idx);
                idx++;
            end
        end

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim/stream_input.txt
// Columns: tag nibble then 32-bit word; tag 8 test marker, 1 header, 0 data, f end
// Header word: frame id, data word count, 16 reserved bits
800000002
101030000 0a1b20001 0a1b20002 0a1b20003
102000000
103050000 0c3d40001 0c3d40002 0c3d40003 0c3d40004 0c3d40005
104010000 0d5e60001
800000003
800000004
105060000 05a5a0001 05a5a0002 05a5a0003 05a5a0004 05a5a0005 05a5a0006
106000000
107020000 07c7c0001 07c7c0002
800000005
108430000 0ee000001 0ee000002 0ee000003 0ee000004 0ee000005 0ee000006 0ee000007
0ee000008 0ee000009 0ee00000a 0ee00000b 0ee00000c 0ee00000d 0ee00000e 0ee00000f
0ee000010 0ee000011 0ee000012 0ee000013 0ee000014 0ee000015 0ee000016 0ee000017
0ee000018 0ee000019 0ee00001a 0ee00001b 0ee00001c 0ee00001d 0ee00001e 0ee00001f
0ee000020 0ee000021 0ee000022 0ee000023 0ee000024 0ee000025 0ee000026 0ee000027
0ee000028 0ee000029 0ee00002a 0ee00002b 0ee00002c 0ee00002d 0ee00002e 0ee00002f
0ee000030 0ee000031 0ee000032 0ee000033 0ee000034 0ee000035 0ee000036 0ee000037
0ee000038 0ee000039 0ee00003a 0ee00003b 0ee00003c 0ee00003d 0ee00003e 0ee00003f
0ee000040 0ee000041 0ee000042 0ee000043
f00000000

// File: all.f
+incdir+common
common/stream_types_pkg.sv
common/buffer_ctrl_pkg.sv
block_buffer/dual_port_ram.sv
block_buffer/bram_blocks_rw.sv
src/stream_ctrl.sv
src/frame_tracker.sv
src/block_stream_top.sv
sim/tb_block_stream.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_block_stream -o tb_block_stream

output=$(./obj_dir/tb_block_stream 2>&1) || true
echo "$output"

if grep -qx "Simulation completed successfully" <<< "$output"; then
    exit 0
fi
exit 1
